// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_stage2_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
src/decode_pkg.sv
src/field_extract.sv
src/seg_select.sv
src/uop_sequencer.sv
src/operand_ctrl.sv
src/eip_exc_ctrl.sv
src/decode_stage2.sv
verification/decode_stage2_sva.sv
verification/decode_stage2_tb.sv

// ==== src/decode_pkg.sv ====
package decode_pkg;

   // control store geometry
   localparam int UADDR_W     = 4;
   localparam int UCODE_DEPTH = 16;

   // segment register codes
   localparam logic [2:0] SEG_ES = 3'd0;
   localparam logic [2:0] SEG_CS = 3'd1;
   localparam logic [2:0] SEG_SS = 3'd2;
   localparam logic [2:0] SEG_DS = 3'd3;
   localparam logic [2:0] SEG_FS = 3'd4;
   localparam logic [2:0] SEG_GS = 3'd5;

   // operand size codes
   localparam logic [1:0] SIZE_8  = 2'd0;
   localparam logic [1:0] SIZE_16 = 2'd1;
   localparam logic [1:0] SIZE_32 = 2'd2;
   localparam logic [1:0] SIZE_64 = 2'd3;

   // fields found by decode stage one
   typedef struct packed {
      logic [15:0]        opcode;
      logic [7:0]         modrm;
      logic [7:0]         sib;
      logic               modrm_present;
      logic               sib_present;
      logic               disp_present;
      logic [2:0]         disp_sel;
      logic               disp_size;
      logic [3:0]         imm_sel;
      logic [1:0]         imm_size;
      logic               segment_override;
      logic [2:0]         seg_id;
      logic               operand_override;
      logic               repeat_prefix;
      logic [3:0]         instr_length;
      logic [UADDR_W-1:0] decode_address;
   } d1_fields_t;

   // microcode control word, each mux_* bit selects the control value
   typedef struct packed {
      logic               uop_stall;
      logic [UADDR_W-1:0] next_uaddr;
      logic [1:0]         op_size;
      logic               mux_op_size;
      logic               mux_sr1_size;
      logic [1:0]         sr2_size;
      logic               mux_sr2_size;
      logic               mux_dr1_size;
      logic               mux_dr2_size;
      logic               seg1_needed;
      logic               mux_seg1_needed;
      logic               mem_rd;
      logic               mux_mem_rd;
      logic               mem_wr;
      logic               mux_mem_wr;
      logic               ld_gpr1;
      logic               ld_mm;
      logic               sr1_needed;
      logic               mm1_needed;
      logic [2:0]         aluk;
      logic               mux_aluk;
      logic [2:0]         sr1;
      logic               mux_sr1;
      logic [2:0]         sr2;
      logic               mux_sr2;
      logic               mux_seg1;
      logic               mux_seg2;
      logic               jmp_stall;
      logic               is_far;
   } ucode_word_t;

   // to address generation
   typedef struct packed {
      logic [1:0] sr1_size;
      logic [1:0] sr2_size;
      logic       sr1_needed;
      logic       seg1_needed;
      logic       mm1_needed;
      logic [2:0] sr1;
      logic [2:0] sr2;
      logic [2:0] sr3;
      logic [2:0] sr4;
      logic [2:0] seg1;
      logic [2:0] seg2;
      logic       sib_en;
      logic       disp_en;
      logic       base_reg_en;
      logic [1:0] sib_scale;
      logic       mux_seg;
      logic       cmpxchg;
   } ag_ctrl_t;

   // to memory and writeback
   typedef struct packed {
      logic [1:0] dr1_size;
      logic [1:0] dr2_size;
      logic [1:0] mem_size;
      logic       mem_rd;
      logic       mem_wr;
      logic [2:0] aluk;
      logic       ld_gpr1;
      logic       ld_mm;
      logic       repne;
   } wb_ctrl_t;

   // entries 3, 7 and 11 start two-uop flows ending at 12, 13 and 14
   localparam ucode_word_t UCODE_TABLE [UCODE_DEPTH] = '{
      '{default: '0},
      '{ld_gpr1: 1'b1, sr1_needed: 1'b1, default: '0},
      '{mux_op_size: 1'b1, op_size: SIZE_8, ld_gpr1: 1'b1, default: '0},
      '{uop_stall: 1'b1, next_uaddr: 4'd12, mux_mem_rd: 1'b1, mem_rd: 1'b1,
        mux_seg1_needed: 1'b1, seg1_needed: 1'b1, mux_mem_wr: 1'b1, default: '0},
      '{mux_sr1: 1'b1, sr1: 3'd4, mux_seg2: 1'b1, sr1_needed: 1'b1, default: '0},
      '{ld_mm: 1'b1, mm1_needed: 1'b1, mux_op_size: 1'b1, op_size: SIZE_64,
        default: '0},
      '{jmp_stall: 1'b1, mux_aluk: 1'b1, aluk: 3'd7, mux_mem_rd: 1'b1, default: '0},
      '{uop_stall: 1'b1, next_uaddr: 4'd13, is_far: 1'b1, mux_sr1: 1'b1, sr1: 3'd4,
        mux_mem_wr: 1'b1, mem_wr: 1'b1, default: '0},
      '{mux_dr1_size: 1'b1, mux_dr2_size: 1'b1, ld_gpr1: 1'b1, default: '0},
      '{mux_sr2_size: 1'b1, sr2_size: SIZE_16, mux_sr2: 1'b1, sr2: 3'd1,
        default: '0},
      '{mux_seg1: 1'b1, mux_mem_wr: 1'b1, mem_wr: 1'b1, mux_aluk: 1'b1, aluk: 3'd2,
        default: '0},
      '{uop_stall: 1'b1, next_uaddr: 4'd14, mux_mem_rd: 1'b1, mem_rd: 1'b1,
        mux_sr1_size: 1'b1, default: '0},
      '{mux_mem_wr: 1'b1, mem_wr: 1'b1, mux_sr1: 1'b1, sr1: 3'd4, ld_gpr1: 1'b1,
        default: '0},
      '{is_far: 1'b1, jmp_stall: 1'b1, mux_mem_rd: 1'b1, mem_rd: 1'b1, default: '0},
      '{ld_gpr1: 1'b1, mux_aluk: 1'b1, aluk: 3'd5, mux_dr1_size: 1'b1, default: '0},
      '{mux_seg2: 1'b1, mux_sr1_size: 1'b1, mux_seg1_needed: 1'b1, default: '0}
   };

endpackage

// ==== src/decode_stage2.sv ====
module decode_stage2 (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    d2_v,
   input  logic                    ld_d2,
   input  logic [127:0]            ir,
   input  logic [31:0]             eip,
   input  decode_pkg::d1_fields_t  fields,
   input  logic [2:0]              exc_en,
   input  logic [2:0]              flush,
   output decode_pkg::ucode_word_t ctrl,
   output decode_pkg::ag_ctrl_t    ag,
   output decode_pkg::wb_ctrl_t    wb,
   output logic [31:0]             disp32,
   output logic [31:0]             imm32,
   output logic [31:0]             eip_next,
   output logic                    uop_stall,
   output logic                    jmp_stall,
   output logic                    exc_v
);

   logic [2:0] seg_eff;
   logic       mux_seg;

   field_extract field_extract_i (
      .ir     (ir),
      .fields (fields),
      .disp32 (disp32),
      .imm32  (imm32)
   );

   seg_select seg_select_i (
      .fields  (fields),
      .seg_eff (seg_eff),
      .mux_seg (mux_seg)
   );

   uop_sequencer uop_sequencer_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .d2_v      (d2_v),
      .ld_d2     (ld_d2),
      .flush     (flush),
      .fields    (fields),
      .ctrl      (ctrl),
      .uop_stall (uop_stall)
   );

   operand_ctrl operand_ctrl_i (
      .fields  (fields),
      .ctrl    (ctrl),
      .seg_eff (seg_eff),
      .mux_seg (mux_seg),
      .ag      (ag),
      .wb      (wb)
   );

   eip_exc_ctrl eip_exc_ctrl_i (
      .eip       (eip),
      .fields    (fields),
      .d2_v      (d2_v),
      .exc_en    (exc_en),
      .ctrl      (ctrl),
      .eip_next  (eip_next),
      .exc_v     (exc_v),
      .jmp_stall (jmp_stall)
   );

endmodule

// ==== src/eip_exc_ctrl.sv ====
module eip_exc_ctrl (
   input  logic [31:0]             eip,
   input  decode_pkg::d1_fields_t  fields,
   input  logic                    d2_v,
   input  logic [2:0]              exc_en,
   input  decode_pkg::ucode_word_t ctrl,
   output logic [31:0]             eip_next,
   output logic                    exc_v,
   output logic                    jmp_stall
);

   logic        exc_any;
   logic [31:0] eip_inc;

   // nmi, general protection or page fault
   assign exc_any = |exc_en;

   assign eip_inc = eip + {28'd0, fields.instr_length};

   // a faulting instruction keeps its own eip for the handler
   assign eip_next = exc_any ? eip : eip_inc;

   assign exc_v = d2_v & exc_any;

   // fetch stalls until the branch target resolves
   assign jmp_stall = d2_v & ctrl.jmp_stall;

endmodule

// ==== src/field_extract.sv ====
module field_extract (
   input  logic [127:0]           ir,
   input  decode_pkg::d1_fields_t fields,
   output logic [31:0]            disp32,
   output logic [31:0]            imm32
);

   // windows shifted so the selected byte lands at bit 0
   logic [127:0] disp_win;
   logic [127:0] imm_win;

   always_comb begin
      disp_win = ir >> {fields.disp_sel, 3'b000};
      imm_win  = ir >> {fields.imm_sel, 3'b000};
   end

   // displacement is either a signed byte or a full dword
   always_comb begin
      if (fields.disp_size) begin
         disp32 = disp_win[31:0];
      end else begin
         disp32 = {{24{disp_win[7]}}, disp_win[7:0]};
      end
   end

   // immediate sizes 2 and 3 both take 32 bits
   always_comb begin
      case (fields.imm_size)
         2'd0: begin
            imm32 = {{24{imm_win[7]}}, imm_win[7:0]};
         end
         2'd1: begin
            imm32 = {{16{imm_win[15]}}, imm_win[15:0]};
         end
         default: begin
            imm32 = imm_win[31:0];
         end
      endcase
   end

endmodule

// ==== src/operand_ctrl.sv ====
module operand_ctrl (
   input  decode_pkg::d1_fields_t  fields,
   input  decode_pkg::ucode_word_t ctrl,
   input  logic [2:0]              seg_eff,
   input  logic                    mux_seg,
   output decode_pkg::ag_ctrl_t    ag,
   output decode_pkg::wb_ctrl_t    wb
);

   logic [1:0] mod;
   logic [2:0] reg_op;
   logic [2:0] rm;
   logic       mod_mem;
   logic       mod_reg;
   logic       mem_modrm;
   logic       op_0f7f;
   logic [1:0] op_size;
   logic [1:0] far_size;
   logic [2:0] base_id;

   assign mod    = fields.modrm[7:6];
   assign reg_op = fields.modrm[5:3];
   assign rm     = fields.modrm[2:0];

   assign mod_mem   = (mod != 2'b11);
   assign mod_reg   = (mod == 2'b11);
   assign mem_modrm = fields.modrm_present & mod_mem;

   // movq mm/m64, mm
   assign op_0f7f = (fields.opcode == 16'h0F7F);

   // 16 under operand override, unless microcode fixes the size
   always_comb begin
      op_size = fields.operand_override ? decode_pkg::SIZE_16 : decode_pkg::SIZE_32;
      if (ctrl.mux_op_size) begin
         op_size = ctrl.op_size;
      end
   end

   // far transfers move the selector along with the offset
   assign far_size = fields.operand_override ? decode_pkg::SIZE_16 : decode_pkg::SIZE_64;

   assign base_id = fields.sib_present ? fields.sib[2:0] : rm;

   always_comb begin
      ag.sr1_size    = (ctrl.mux_sr1_size | mem_modrm) ? decode_pkg::SIZE_32 : op_size;
      ag.sr2_size    = ctrl.mux_sr2_size ? ctrl.sr2_size : op_size;
      ag.sr1_needed  = ctrl.sr1_needed | mem_modrm;
      ag.seg1_needed = ctrl.mux_seg1_needed ? ctrl.seg1_needed : mod_mem;
      ag.mm1_needed  = ctrl.mm1_needed & mod_reg & ~op_0f7f;
      ag.sr1         = ctrl.mux_sr1 ? ctrl.sr1 : base_id;
      ag.sr2         = ctrl.mux_sr2 ? ctrl.sr2 : reg_op;
      ag.sr3         = reg_op;
      ag.sr4         = fields.sib[5:3];
      // string destinations always go through es
      ag.seg1        = ctrl.mux_seg1 ? decode_pkg::SEG_ES : seg_eff;
      ag.seg2        = ctrl.mux_seg2 ? reg_op : decode_pkg::SEG_SS;
      ag.sib_en      = fields.sib_present;
      ag.disp_en     = fields.disp_present;
      // mod 00 rm 101 is disp32 with no base register
      ag.base_reg_en = !(mod == 2'b00 && rm == 3'b101);
      ag.sib_scale   = fields.sib[7:6];
      ag.mux_seg     = mux_seg;
      ag.cmpxchg     = ({fields.opcode[15:1], 1'b0} == 16'h0FB0);
   end

   always_comb begin
      wb.dr1_size = ctrl.mux_dr1_size ? decode_pkg::SIZE_32 : op_size;
      wb.dr2_size = ctrl.mux_dr2_size ? decode_pkg::SIZE_32 : op_size;
      wb.mem_size = ctrl.is_far ? far_size : op_size;
      wb.mem_rd   = ctrl.mux_mem_rd ? ctrl.mem_rd : mod_mem;
      wb.mem_wr   = ctrl.mux_mem_wr ? ctrl.mem_wr : mod_mem;
      wb.aluk     = ctrl.mux_aluk ? ctrl.aluk : reg_op;
      wb.ld_gpr1  = ctrl.ld_gpr1 & ~mem_modrm;
      wb.ld_mm    = ctrl.ld_mm | (mod_reg & op_0f7f);
      wb.repne    = fields.repeat_prefix;
   end

endmodule

// ==== src/seg_select.sv ====
module seg_select (
   input  decode_pkg::d1_fields_t fields,
   output logic [2:0]             seg_eff,
   output logic                   mux_seg
);

   logic       push_pop_hit;
   logic [2:0] push_pop_seg;
   logic       stack_base;

   // push/pop of a segment register names that segment
   always_comb begin
      push_pop_hit = 1'b1;
      case (fields.opcode)
         16'h0006, 16'h0007: push_pop_seg = decode_pkg::SEG_ES;
         16'h000E:           push_pop_seg = decode_pkg::SEG_CS;
         16'h0016, 16'h0017: push_pop_seg = decode_pkg::SEG_SS;
         16'h001E, 16'h001F: push_pop_seg = decode_pkg::SEG_DS;
         16'h0FA0, 16'h0FA1: push_pop_seg = decode_pkg::SEG_FS;
         16'h0FA8, 16'h0FA9: push_pop_seg = decode_pkg::SEG_GS;
         default: begin
            push_pop_hit = 1'b0;
            push_pop_seg = decode_pkg::SEG_DS;
         end
      endcase
   end

   // esp as sib base, or ebp with a displacement
   assign stack_base = (fields.sib_present && fields.sib[2:0] == 3'b100) ||
                       (fields.modrm_present &&
                        (fields.modrm[7:6] == 2'b01 || fields.modrm[7:6] == 2'b10) &&
                        fields.modrm[2:0] == 3'b101);

   always_comb begin
      if (fields.segment_override) begin
         seg_eff = fields.seg_id;
      end else if (push_pop_hit) begin
         seg_eff = push_pop_seg;
      end else if (stack_base) begin
         seg_eff = decode_pkg::SEG_SS;
      end else begin
         seg_eff = decode_pkg::SEG_DS;
      end
   end

   assign mux_seg = fields.segment_override && (fields.seg_id == decode_pkg::SEG_CS);

endmodule

// ==== src/uop_sequencer.sv ====
module uop_sequencer (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    d2_v,
   input  logic                    ld_d2,
   input  logic [2:0]              flush,
   input  decode_pkg::d1_fields_t  fields,
   output decode_pkg::ucode_word_t ctrl,
   output logic                    uop_stall
);

   // continuation state
   logic                             uop_active;
   logic [decode_pkg::UADDR_W-1:0]   saved_uaddr;
   logic [decode_pkg::UADDR_W-1:0]   uaddr;
   logic                             flush_any;

   assign flush_any = |flush;

   // follow the chain while a multi-uop flow is in progress
   assign uaddr = uop_active ? saved_uaddr : fields.decode_address;

   assign ctrl = decode_pkg::UCODE_TABLE[uaddr];

   // interrupt, repne terminate or mispredict kills the flow
   assign uop_stall = d2_v & ctrl.uop_stall & ~flush_any;

   // next address only advances when the next stage takes this uop
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         saved_uaddr <= '0;
      end else if (d2_v && ld_d2) begin
         saved_uaddr <= ctrl.next_uaddr;
      end
   end

   // a flush forces the flag to update even under back-pressure
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         uop_active <= 1'b0;
      end else if (ld_d2 || flush_any) begin
         uop_active <= uop_stall;
      end
   end

endmodule

// ==== verification/decode_stage2_sva.sv ====
module decode_stage2_sva (
   input logic                           clk,
   input logic                           arst_n,
   input logic                           d2_v,
   input logic                           ld_d2,
   input logic [2:0]                     flush,
   input decode_pkg::d1_fields_t         fields,
   input decode_pkg::ucode_word_t        ctrl,
   input logic                           uop_stall,
   input logic                           uop_active,
   input logic [decode_pkg::UADDR_W-1:0] saved_uaddr
);
   timeunit 1ns;
   timeprecision 1ps;

   // no continuation request without a valid instruction
   stall_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
      !d2_v |-> !uop_stall)
      else $error("uop_stall high while d2_v is low");

   // first cycle out of reset reads the stage one address
   reset_uses_decode: assert property (@(posedge clk)
      $rose(arst_n) |-> ctrl == decode_pkg::UCODE_TABLE[fields.decode_address])
      else $error("first cycle after reset did not use decode_address");

   // back-pressure without flush freezes the sequencer
   state_holds: assert property (@(posedge clk) disable iff (!arst_n)
      (!ld_d2 && flush == 3'b000) |=> ($stable(uop_active) && $stable(saved_uaddr)))
      else $error("sequencer state changed under back-pressure");

endmodule

// ==== verification/decode_stage2_tb.sv ====
module decode_stage2_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_TESTS         = 5;
   localparam int CYCLES_PER_TEST = 300;
   localparam int RESET_CYCLES    = 2;
   localparam int TIMEOUT_CYCLES  = 2 * (N_TESTS * CYCLES_PER_TEST + RESET_CYCLES);

   logic                    clk;
   logic                    arst_n;
   logic                    d2_v;
   logic                    ld_d2;
   logic [127:0]            ir;
   logic [31:0]             eip;
   decode_pkg::d1_fields_t  fields;
   logic [2:0]              exc_en;
   logic [2:0]              flush;
   decode_pkg::ucode_word_t ctrl;
   decode_pkg::ag_ctrl_t    ag;
   decode_pkg::wb_ctrl_t    wb;
   logic [31:0]             disp32;
   logic [31:0]             imm32;
   logic [31:0]             eip_next;
   logic                    uop_stall;
   logic                    jmp_stall;
   logic                    exc_v;

   // model copy of the sequencer state
   logic                           model_active;
   logic [decode_pkg::UADDR_W-1:0] model_saved;

   logic [31:0] seed = 32'h6d22b16d;
   int          errors = 0;
   int          checks = 0;
   int          test_errors = 0;
   int          cycle_count = 0;

   // segment push/pop opcodes plus one near miss
   logic [15:0] seg_ops [12] = '{16'h0006, 16'h0007, 16'h000E, 16'h0016, 16'h0017,
      16'h001E, 16'h001F, 16'h0FA0, 16'h0FA1, 16'h0FA8, 16'h0FA9, 16'h000F};

   decode_stage2 decode_stage2_i (.*);

   bind decode_stage2 decode_stage2_sva decode_stage2_sva_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .d2_v        (d2_v),
      .ld_d2       (ld_d2),
      .flush       (flush),
      .fields      (fields),
      .ctrl        (ctrl),
      .uop_stall   (uop_stall),
      .uop_active  (uop_sequencer_i.uop_active),
      .saved_uaddr (uop_sequencer_i.saved_uaddr)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // low bits of the LCG are weak, so the halves are swapped
   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return {seed[15:0], seed[31:16]};
   endfunction

   task automatic compare(input string what, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         test_errors++;
         $display("ERR %s: expected %h, actual %h", what, expected, actual);
      end
   endtask

   // bytes past the end of the window read as zero
   function automatic logic [31:0] window_bytes(input logic [127:0] win, input int start);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < 4; k++) begin
         if (start + k < 16) begin
            v[8*k +: 8] = win[8*(start+k) +: 8];
         end
      end
      return v;
   endfunction

   function automatic logic [31:0] expect_disp(input logic [127:0] win,
                                               input decode_pkg::d1_fields_t f);
      logic [31:0] raw;
      raw = window_bytes(win, int'(f.disp_sel));
      return f.disp_size ? raw : 32'($signed(raw[7:0]));
   endfunction

   function automatic logic [31:0] expect_imm(input logic [127:0] win,
                                              input decode_pkg::d1_fields_t f);
      logic [31:0] raw;
      raw = window_bytes(win, int'(f.imm_sel));
      case (f.imm_size)
         2'd0: return 32'($signed(raw[7:0]));
         2'd1: return 32'($signed(raw[15:0]));
         default: return raw;
      endcase
   endfunction

   function automatic logic [2:0] expect_seg(input decode_pkg::d1_fields_t f);
      if (f.segment_override) return f.seg_id;
      if (f.opcode inside {16'h0006, 16'h0007}) return decode_pkg::SEG_ES;
      if (f.opcode == 16'h000E) return decode_pkg::SEG_CS;
      if (f.opcode inside {16'h0016, 16'h0017}) return decode_pkg::SEG_SS;
      if (f.opcode inside {16'h001E, 16'h001F}) return decode_pkg::SEG_DS;
      if (f.opcode inside {16'h0FA0, 16'h0FA1}) return decode_pkg::SEG_FS;
      if (f.opcode inside {16'h0FA8, 16'h0FA9}) return decode_pkg::SEG_GS;
      if (f.sib_present && f.sib[2:0] == 3'b100) return decode_pkg::SEG_SS;
      if (f.modrm_present && f.modrm[7:6] inside {2'b01, 2'b10} && f.modrm[2:0] == 3'b101)
         return decode_pkg::SEG_SS;
      return decode_pkg::SEG_DS;
   endfunction

   task automatic model_operands(input decode_pkg::d1_fields_t f,
                                 input decode_pkg::ucode_word_t c,
                                 output decode_pkg::ag_ctrl_t a,
                                 output decode_pkg::wb_ctrl_t w);
      logic       mem;
      logic       mreg;
      logic [1:0] base;
      mem  = f.modrm[7:6] != 2'b11;
      mreg = !mem;
      base = f.operand_override ? decode_pkg::SIZE_16 : decode_pkg::SIZE_32;
      if (c.mux_op_size) base = c.op_size;
      a = '0;
      a.sr1_size    = (c.mux_sr1_size || (f.modrm_present && mem)) ? decode_pkg::SIZE_32 : base;
      a.sr2_size    = c.mux_sr2_size ? c.sr2_size : base;
      a.sr1_needed  = c.sr1_needed || (f.modrm_present && mem);
      a.seg1_needed = c.mux_seg1_needed ? c.seg1_needed : mem;
      a.mm1_needed  = c.mm1_needed && mreg && f.opcode != 16'h0F7F;
      a.sr1         = c.mux_sr1 ? c.sr1 : (f.sib_present ? f.sib[2:0] : f.modrm[2:0]);
      a.sr2         = c.mux_sr2 ? c.sr2 : f.modrm[5:3];
      // sr3 carries the reg field and sr4 the sib index
      a.sr3         = f.modrm[5:3];
      a.sr4         = f.sib[5:3];
      a.seg1        = c.mux_seg1 ? decode_pkg::SEG_ES : expect_seg(f);
      a.seg2        = c.mux_seg2 ? f.modrm[5:3] : decode_pkg::SEG_SS;
      a.sib_en      = f.sib_present;
      a.disp_en     = f.disp_present;
      a.base_reg_en = !(f.modrm[7:6] == 2'b00 && f.modrm[2:0] == 3'b101);
      a.sib_scale   = f.sib[7:6];
      a.mux_seg     = f.segment_override && f.seg_id == decode_pkg::SEG_CS;
      a.cmpxchg     = f.opcode inside {16'h0FB0, 16'h0FB1};
      w.dr1_size = c.mux_dr1_size ? decode_pkg::SIZE_32 : base;
      w.dr2_size = c.mux_dr2_size ? decode_pkg::SIZE_32 : base;
      w.mem_size = base;
      if (c.is_far)
         w.mem_size = f.operand_override ? decode_pkg::SIZE_16 : decode_pkg::SIZE_64;
      w.mem_rd  = c.mux_mem_rd ? c.mem_rd : mem;
      w.mem_wr  = c.mux_mem_wr ? c.mem_wr : mem;
      w.aluk    = c.mux_aluk ? c.aluk : f.modrm[5:3];
      w.ld_gpr1 = c.ld_gpr1 && !(f.modrm_present && mem);
      w.ld_mm   = c.ld_mm || (mreg && f.opcode == 16'h0F7F);
      w.repne   = f.repeat_prefix;
   endtask

   task automatic randomize_inputs(input int test_id);
      logic [63:0] raw;
      logic [31:0] r;
      logic [31:0] pick;
      raw = {lcg_next(), lcg_next()};
      r   = lcg_next();
      fields = raw[$bits(decode_pkg::d1_fields_t)-1:0];
      ir     = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      eip    = lcg_next();
      d2_v   = r[0];
      ld_d2  = 1'b1;
      flush  = 3'b000;
      exc_en = 3'b000;
      pick   = lcg_next() % 32'd6;
      fields.seg_id = pick[2:0];
      fields.segment_override = r[21] & r[22];
      if (test_id == 2 && r[20]) begin
         pick = lcg_next() % 32'd12;
         fields.opcode = seg_ops[pick[3:0]];
      end
      if (test_id == 3) begin
         case (r[25:24])
            2'd0: fields.opcode = 16'h0F7F;
            2'd1: fields.opcode = 16'h0FB0;
            2'd2: fields.opcode = 16'h0FB1;
            default: ;
         endcase
      end
      if (test_id == 4) begin
         // mostly valid, some back-pressure, rare flush, frequent multi-uop entries
         d2_v  = r[3:0] != 4'd0;
         ld_d2 = r[5:4] != 2'd0;
         flush = (r[9:7] == 3'd0) ? r[12:10] : 3'b000;
         fields.decode_address = r[13] ? {r[15:14], 2'b11} : r[19:16];
      end
      if (test_id == 5) exc_en = (r[27:26] == 2'd0) ? 3'b000 : r[30:28];
   endtask

   task automatic run_cycle(input int test_id, input string name);
      logic [decode_pkg::UADDR_W-1:0] uaddr;
      decode_pkg::ucode_word_t        c;
      decode_pkg::ag_ctrl_t           exp_ag;
      decode_pkg::wb_ctrl_t           exp_wb;
      logic [31:0]                    exp_eip;
      logic                           stall;
      @(negedge clk);
      randomize_inputs(test_id);
      #2;
      uaddr = model_active ? model_saved : fields.decode_address;
      c     = decode_pkg::UCODE_TABLE[uaddr];
      stall = d2_v && c.uop_stall && flush == 3'b000;
      model_operands(fields, c, exp_ag, exp_wb);
      exp_eip = (exc_en != 3'b000) ? eip : eip + 32'(fields.instr_length);
      case (test_id)
         1: begin
            compare({name, " disp32"}, 64'(expect_disp(ir, fields)), 64'(disp32));
            compare({name, " imm32"}, 64'(expect_imm(ir, fields)), 64'(imm32));
         end
         2: begin
            compare({name, " seg1"}, 64'(exp_ag.seg1), 64'(ag.seg1));
            compare({name, " mux_seg"}, 64'(exp_ag.mux_seg), 64'(ag.mux_seg));
         end
         3: begin
            compare({name, " ag"}, 64'(exp_ag), 64'(ag));
            compare({name, " wb"}, 64'(exp_wb), 64'(wb));
         end
         4: begin
            compare({name, " ctrl"}, 64'(c), 64'(ctrl));
            compare({name, " uop_stall"}, 64'(stall), 64'(uop_stall));
         end
         default: begin
            compare({name, " eip_next"}, 64'(exp_eip), 64'(eip_next));
            compare({name, " exc_v"}, 64'(d2_v && exc_en != 3'b000), 64'(exc_v));
            compare({name, " jmp_stall"}, 64'(d2_v && c.jmp_stall), 64'(jmp_stall));
         end
      endcase
      // state advances on the coming rising edge
      if (d2_v && ld_d2) model_saved = c.next_uaddr;
      if (ld_d2 || flush != 3'b000) model_active = stall;
   endtask

   task automatic run_test(input int test_id, input string name);
      test_errors = 0;
      repeat (CYCLES_PER_TEST) run_cycle(test_id, name);
      $display("test %0d %s: %0d cycles, %0d errors", test_id, name, CYCLES_PER_TEST,
               test_errors);
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      d2_v = 1'b0;
      ld_d2 = 1'b0;
      ir = '0;
      eip = '0;
      fields = '0;
      exc_en = '0;
      flush = '0;
      model_active = 1'b0;
      model_saved = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      run_test(1, "disp_imm");
      run_test(2, "segment");
      run_test(3, "operands");
      run_test(4, "sequencing");
      run_test(5, "eip_exc");
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
